// ==== Makefile ====
TOP := tb_adc_emul

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== hdl/adc_capture.sv ====
`timescale 1ns/1ns

module adc_capture
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic [emul_pkg::HALF_W-1:0]     i_adc_p,
    input  logic [emul_pkg::HALF_W-1:0]     i_adc_n,
    input  logic                            i_adc_or,
    output emul_pkg::adc_sample_t           o_sample,
    output logic                            o_over_range
);

    logic [emul_pkg::HALF_W-1:0]     p_q;
    logic [emul_pkg::HALF_W-1:0]     n_q;
    logic                            or_q;
    logic [emul_pkg::OR_CNT_W-1:0]   or_cnt;

    // first stage, capture both halves
    always_ff @(posedge clk)
    begin
        p_q <= i_adc_p;
        n_q <= i_adc_n;
    end

    // second stage, odd bits from the rising half
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < emul_pkg::HALF_W; k++)
        begin
            o_sample[2*k+1] <= p_q[k];
            o_sample[2*k]   <= n_q[k];
        end
    end

    // over-range stretch
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            or_q         <= 1'b0;
            or_cnt       <= '0;
            o_over_range <= 1'b0;
        end
        else
        begin
            or_q <= i_adc_or;
            if (or_q)
            begin
                or_cnt <= emul_pkg::OR_CNT_W'(emul_pkg::OR_STRETCH);
            end
            else if (or_cnt != '0)
            begin
                or_cnt <= or_cnt - 1'b1;
            end
            // flag cycle plus OR_STRETCH countdown cycles
            o_over_range <= or_q || (or_cnt != '0);
        end
    end

endmodule

// ==== hdl/adc_emul.sv ====
`timescale 1ns/1ns

module adc_emul
(
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_reg_req,
    input  emul_pkg::reg_cmd_t              i_reg_cmd,
    input  logic [emul_pkg::HALF_W-1:0]     i_adc_p,
    input  logic [emul_pkg::HALF_W-1:0]     i_adc_n,
    input  logic                            i_adc_or,
    input  logic                            i_fifo_full,
    output logic                            o_reg_ack,
    output logic [emul_pkg::REG_W-1:0]      o_reg_rdata,
    output logic                            o_strobe,
    output logic                            o_soa,
    output logic                            o_over_range,
    output logic                            o_fifo_wr,
    output emul_pkg::fifo_word_t            o_fifo_din,
    output logic                            o_fifo_reset
);

    emul_pkg::timing_cfg_t          cfg;
    emul_pkg::frame_pos_t           frame_pos;
    logic                           frame_start;
    emul_pkg::adc_sample_t          sample;
    logic [emul_pkg::REG_W-1:0]     fifo_err;

    // host registers
    reg_bank reg_bank_i
    (
        .clk          (clk),
        .reset        (reset),
        .i_reg_req    (i_reg_req),
        .i_reg_cmd    (i_reg_cmd),
        .i_fifo_err   (fifo_err),
        .o_reg_ack    (o_reg_ack),
        .o_reg_rdata  (o_reg_rdata),
        .o_cfg        (cfg),
        .o_fifo_reset (o_fifo_reset)
    );

    // ddr halves to samples
    adc_capture adc_capture_i
    (
        .clk          (clk),
        .reset        (reset),
        .i_adc_p      (i_adc_p),
        .i_adc_n      (i_adc_n),
        .i_adc_or     (i_adc_or),
        .o_sample     (sample),
        .o_over_range (o_over_range)
    );

    pulse_timer pulse_timer_i
    (
        .clk           (clk),
        .reset         (reset),
        .i_cfg         (cfg),
        .o_strobe      (o_strobe),
        .o_soa         (o_soa),
        .o_frame_pos   (frame_pos),
        .o_frame_start (frame_start)
    );

    // fifo side
    sample_packer sample_packer_i
    (
        .clk           (clk),
        .reset         (reset),
        .i_cfg         (cfg),
        .i_sample      (sample),
        .i_frame_pos   (frame_pos),
        .i_frame_start (frame_start),
        .i_fifo_full   (i_fifo_full),
        .o_fifo_wr     (o_fifo_wr),
        .o_fifo_din    (o_fifo_din),
        .o_fifo_err    (fifo_err)
    );

endmodule

// ==== hdl/emul_pkg.sv ====
package emul_pkg;

    // data widths
    localparam int REG_W            = 32;
    localparam int ADDR_W           = 4;
    localparam int SAMPLE_W         = 16;
    localparam int HALF_W           = 8;
    localparam int WORD_W           = 64;
    localparam int SAMPLES_PER_WORD = 4;

    // over-range hold time in clk cycles
    localparam int OR_STRETCH = 16;
    localparam int OR_CNT_W   = $clog2(OR_STRETCH + 1);

    // register map
    localparam logic [ADDR_W-1:0] ADDR_PERIOD     = 4'd1;
    localparam logic [ADDR_W-1:0] ADDR_ENABLE     = 4'd2;
    localparam logic [ADDR_W-1:0] ADDR_STROBE_LEN = 4'd3;
    localparam logic [ADDR_W-1:0] ADDR_SOA_LEN    = 4'd4;
    localparam logic [ADDR_W-1:0] ADDR_FIFO_ERR   = 4'd5;

    // values after reset
    localparam logic [REG_W-1:0] DEF_PERIOD     = 32'd60000;
    localparam logic [REG_W-1:0] DEF_STROBE_LEN = 32'd630;
    localparam logic [REG_W-1:0] DEF_SOA_LEN    = 32'd8;

    typedef logic [REG_W-1:0]    frame_pos_t;
    typedef logic [SAMPLE_W-1:0] adc_sample_t;
    typedef logic [WORD_W-1:0]   fifo_word_t;

    // one host access
    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [REG_W-1:0]  data;
    } reg_cmd_t;

    // frame settings shared by the timer and the packer
    typedef struct packed {
        logic             enable;
        logic [REG_W-1:0] period;
        logic [REG_W-1:0] strobe_len;
        logic [REG_W-1:0] soa_len;
    } timing_cfg_t;

endpackage

// ==== hdl/pulse_timer.sv ====
`timescale 1ns/1ns

module pulse_timer
(
    input  logic                     clk,
    input  logic                     reset,
    input  emul_pkg::timing_cfg_t    i_cfg,
    output logic                     o_strobe,
    output logic                     o_soa,
    output emul_pkg::frame_pos_t     o_frame_pos,
    output logic                     o_frame_start
);

    emul_pkg::frame_pos_t pos;

    assign o_frame_pos   = pos;
    assign o_frame_start = i_cfg.enable && (pos == '0);

    // frame position, period+1 cycles per frame
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pos <= '0;
        end
        else if (!i_cfg.enable)
        begin
            pos <= '0;
        end
        else if (pos >= i_cfg.period)
        begin
            // also wraps at once if period shrinks below pos
            pos <= '0;
        end
        else
        begin
            pos <= pos + 1'b1;
        end
    end

    // gates, one cycle behind the position
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            o_strobe <= 1'b0;
            o_soa    <= 1'b0;
        end
        else
        begin
            o_strobe <= i_cfg.enable && (pos <= i_cfg.strobe_len);
            o_soa    <= i_cfg.enable && (pos <= i_cfg.soa_len);
        end
    end

    // once period settles the position stays inside the frame
    a_pos_in_frame : assert property (
        @(posedge clk) disable iff (!reset)
        (i_cfg.enable && $stable(i_cfg.period)) |-> (pos <= i_cfg.period)
    );

endmodule

// ==== hdl/reg_bank.sv ====
`timescale 1ns/1ns

module reg_bank
(
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           i_reg_req,
    input  emul_pkg::reg_cmd_t             i_reg_cmd,
    input  logic [emul_pkg::REG_W-1:0]     i_fifo_err,
    output logic                           o_reg_ack,
    output logic [emul_pkg::REG_W-1:0]     o_reg_rdata,
    output emul_pkg::timing_cfg_t          o_cfg,
    output logic                           o_fifo_reset
);

    typedef enum logic
    {
        ST_IDLE,
        ST_ACK
    } hs_state_t;

    hs_state_t                       state;
    logic [emul_pkg::REG_W-1:0]      rd_val;
    logic                            access;

    // a request is taken only from idle, so ack is low before the next one
    assign access    = (state == ST_IDLE) && i_reg_req;
    assign o_reg_ack = (state == ST_ACK);

    // read mux
    always_comb
    begin
        case (i_reg_cmd.addr)
            emul_pkg::ADDR_PERIOD:     rd_val = o_cfg.period;
            emul_pkg::ADDR_ENABLE:     rd_val = emul_pkg::REG_W'(o_cfg.enable);
            emul_pkg::ADDR_STROBE_LEN: rd_val = o_cfg.strobe_len;
            emul_pkg::ADDR_SOA_LEN:    rd_val = o_cfg.soa_len;
            emul_pkg::ADDR_FIFO_ERR:   rd_val = i_fifo_err;
            default:                   rd_val = '0;
        endcase
    end

    // handshake and settings
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state            <= ST_IDLE;
            o_fifo_reset     <= 1'b0;
            o_cfg.enable     <= 1'b0;
            o_cfg.period     <= emul_pkg::DEF_PERIOD;
            o_cfg.strobe_len <= emul_pkg::DEF_STROBE_LEN;
            o_cfg.soa_len    <= emul_pkg::DEF_SOA_LEN;
        end
        else
        begin
            o_fifo_reset <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (i_reg_req)
                    begin
                        state <= ST_ACK;
                        if (i_reg_cmd.wr)
                        begin
                            case (i_reg_cmd.addr)
                                emul_pkg::ADDR_PERIOD:
                                    o_cfg.period <= i_reg_cmd.data;
                                emul_pkg::ADDR_ENABLE:
                                    o_cfg.enable <= (i_reg_cmd.data != '0);
                                emul_pkg::ADDR_STROBE_LEN:
                                    o_cfg.strobe_len <= i_reg_cmd.data;
                                emul_pkg::ADDR_SOA_LEN:
                                    o_cfg.soa_len <= i_reg_cmd.data;
                                // write only pulses the fifo reset
                                emul_pkg::ADDR_FIFO_ERR:
                                    o_fifo_reset <= 1'b1;
                                default:
                                    ;
                            endcase
                        end
                    end
                end
                ST_ACK:
                begin
                    if (!i_reg_req)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // read data held while ack is up
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            o_reg_rdata <= rd_val;
        end
    end

    // ack only ever answers a request seen on the cycle before
    a_ack_needs_req : assert property (
        @(posedge clk) disable iff (!reset)
        $rose(o_reg_ack) |-> $past(i_reg_req)
    );

endmodule

// ==== hdl/sample_packer.sv ====
`timescale 1ns/1ns

module sample_packer
(
    input  logic                           clk,
    input  logic                           reset,
    input  emul_pkg::timing_cfg_t          i_cfg,
    input  emul_pkg::adc_sample_t          i_sample,
    input  emul_pkg::frame_pos_t           i_frame_pos,
    input  logic                           i_frame_start,
    input  logic                           i_fifo_full,
    output logic                           o_fifo_wr,
    output emul_pkg::fifo_word_t           o_fifo_din,
    output logic [emul_pkg::REG_W-1:0]     o_fifo_err
);

    localparam int SLOT_W = $clog2(emul_pkg::SAMPLES_PER_WORD);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(emul_pkg::SAMPLES_PER_WORD - 1);

    logic [SLOT_W-1:0]       slot_q;
    logic [SLOT_W-1:0]       cur_slot;
    logic                    last_slot;
    emul_pkg::fifo_word_t    word_q;
    emul_pkg::fifo_word_t    word_next;
    logic                    suppress;
    emul_pkg::frame_pos_t    mark_pos;

    // slot count restarts on each frame
    assign cur_slot  = i_frame_start ? '0 : slot_q;
    assign last_slot = i_cfg.enable && (cur_slot == LAST_SLOT);

    // slot order 63:48, 15:0, 31:16, 47:32
    always_comb
    begin
        word_next = word_q;
        case (cur_slot)
            2'd0: word_next[63:48] = i_sample;
            2'd1: word_next[15:0]  = i_sample;
            2'd2: word_next[31:16] = i_sample;
            2'd3: word_next[47:32] = i_sample;
            default: word_next = word_q;
        endcase
    end

    always_ff @(posedge clk)
    begin
        word_q <= word_next;
        if (last_slot && !i_fifo_full)
        begin
            o_fifo_din <= word_next;
        end
    end

    // write control and overflow handling
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            slot_q     <= '0;
            o_fifo_wr  <= 1'b0;
            suppress   <= 1'b0;
            mark_pos   <= '0;
            o_fifo_err <= '0;
        end
        else if (!i_cfg.enable)
        begin
            // error count survives a disable
            slot_q    <= '0;
            o_fifo_wr <= 1'b0;
            suppress  <= 1'b0;
            mark_pos  <= '0;
        end
        else
        begin
            slot_q    <= cur_slot + 1'b1;
            o_fifo_wr <= 1'b0;
            if (last_slot)
            begin
                if (i_fifo_full)
                begin
                    o_fifo_err <= o_fifo_err + 1'b1;
                    if (!suppress)
                    begin
                        suppress <= 1'b1;
                        mark_pos <= i_frame_pos;
                    end
                end
                else if (!suppress)
                begin
                    o_fifo_wr <= 1'b1;
                end
                else if (i_frame_pos == mark_pos)
                begin
                    // same spot one frame on, stream is aligned again
                    o_fifo_wr <= 1'b1;
                    suppress  <= 1'b0;
                end
            end
        end
    end

    // a write follows a non-full cycle at the last slot of a frame-aligned word
    a_wr_frame_aligned : assert property (
        @(posedge clk) disable iff (!reset)
        o_fifo_wr |-> ($past(!i_fifo_full) &&
                       ($past(i_frame_pos[SLOT_W-1:0]) == LAST_SLOT))
    );

endmodule

// ==== sim.f ====
hdl/emul_pkg.sv
hdl/reg_bank.sv
hdl/adc_capture.sv
hdl/pulse_timer.sv
hdl/sample_packer.sv
hdl/adc_emul.sv
testbench/tb_adc_emul.sv

// ==== testbench/adc_emul_stim.txt ====
// columns: op a b c, hex. op 1 write a=addr b=data, op 2 read a=addr b=expected
// op 3 run a=frames b=strobe c=soa cycles per frame, op 4 full a=delay b=cycles, op 5 b=or cycles
2 1 0000ea60 0
2 2 0 0
2 3 276 0
2 4 8 0
1 1 27 0
1 3 9 0
1 4 2 0
2 1 27 0
2 3 9 0
2 4 2 0
1 6 5a5a 0
2 6 0 0
1 2 1 0
2 2 1 0
3 4 a 3
4 5 1e 0
3 2 a 3
4 11 50 0
3 1 a 3
5 0 11 0
1 5 0 0
1 2 0 0
2 2 0 0
3 3 0 0

// ==== testbench/tb_adc_emul.sv ====
`timescale 1ns/1ns

module tb_adc_emul;

    localparam int STIM_WORDS = 128;
    localparam int WAIT_LIMIT = 64;

    logic                           clk;
    logic                           reset;
    logic                           i_reg_req;
    emul_pkg::reg_cmd_t             i_reg_cmd;
    logic [emul_pkg::HALF_W-1:0]    i_adc_p;
    logic [emul_pkg::HALF_W-1:0]    i_adc_n;
    logic                           i_adc_or;
    logic                           i_fifo_full;
    logic                           o_reg_ack;
    logic [emul_pkg::REG_W-1:0]     o_reg_rdata;
    logic                           o_strobe;
    logic                           o_soa;
    logic                           o_over_range;
    logic                           o_fifo_wr;
    emul_pkg::fifo_word_t           o_fifo_din;
    logic                           o_fifo_reset;

    logic [31:0]              stim [STIM_WORDS];
    emul_pkg::adc_sample_t    adc_cnt;
    emul_pkg::adc_sample_t    last_first;
    logic                     full_req;
    logic                     or_req;
    logic                     strobe_prev;
    logic                     strobe_rose;
    logic                     pos_valid;
    logic                     have_last;
    logic                     gap_pending;
    logic                     enabled;
    logic                     aborted;
    int                       period;
    int                       pos;
    int                       drops;
    int                       resets_seen;
    int                       words;
    int                       errors;

    adc_emul dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // odd = 1 picks the rising half
    function automatic logic [emul_pkg::HALF_W-1:0] split_half(emul_pkg::adc_sample_t s,
                                                               int odd);
        logic [emul_pkg::HALF_W-1:0] h;
        for (int k = 0; k < emul_pkg::HALF_W; k++)
            h[k] = s[2*k+odd];
        return h;
    endfunction

    task automatic compare_reg(string name, logic [emul_pkg::REG_W-1:0] got,
                               logic [emul_pkg::REG_W-1:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_word(string name, emul_pkg::fifo_word_t got,
                                emul_pkg::fifo_word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_count(string name, int got, int exp);
        if (got != exp)
        begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic give_up(string what);
        errors++;
        aborted = 1'b1;
        $display("timeout: %s", what);
    endtask

    // one clock: sample outputs, update the models, then drive inputs
    task automatic step();
        emul_pkg::fifo_word_t     exp_word;
        emul_pkg::adc_sample_t    first;
        emul_pkg::adc_sample_t    gap;
        @(posedge clk);
        #1;
        strobe_rose = o_strobe && !strobe_prev;
        strobe_prev = o_strobe;
        if (o_fifo_reset)
            resets_seen++;
        if (o_fifo_wr)
        begin
            // slots hold s, s+1, s+2, s+3 at 63:48, 15:0, 31:16, 47:32
            first = o_fifo_din[63:48];
            exp_word = {first, first + 16'd3, first + 16'd2, first + 16'd1};
            compare_word("o_fifo_din", o_fifo_din, exp_word);
            if (gap_pending)
            begin
                // offset from the word that would have come next
                gap = first - last_first - 16'd4;
                compare_count("resume offset mod frame", int'(gap) % (period + 1), 0);
                if (gap == '0)
                begin
                    errors++;
                    $display("writes resumed without skipping a frame after a drop");
                end
                gap_pending = 1'b0;
            end
            last_first = first;
            have_last = 1'b1;
            words++;
        end
        // strobe shows position 0 one cycle late, so the coming cycle is position 1
        if (!enabled)
            pos_valid = 1'b0;
        else if (strobe_rose)
        begin
            pos = 1;
            pos_valid = 1'b1;
        end
        else if (pos_valid)
            pos = (pos >= period) ? 0 : pos + 1;
        i_fifo_full = full_req;
        if (pos_valid && full_req &&
            (pos % emul_pkg::SAMPLES_PER_WORD == emul_pkg::SAMPLES_PER_WORD - 1))
        begin
            drops++;
            gap_pending = have_last;
        end
        i_adc_or = or_req;
        adc_cnt = adc_cnt + 16'd1;
        i_adc_p = split_half(adc_cnt, 1);
        i_adc_n = split_half(adc_cnt, 0);
    endtask

    task automatic reg_access(input logic wr, input logic [emul_pkg::ADDR_W-1:0] addr,
                              input logic [emul_pkg::REG_W-1:0] data,
                              output logic [emul_pkg::REG_W-1:0] rdata);
        int n;
        int resets_before;
        resets_before = resets_seen;
        rdata = '0;
        if (o_reg_ack)
        begin
            give_up("ack still high before a new request");
            return;
        end
        i_reg_cmd.wr = wr;
        i_reg_cmd.addr = addr;
        i_reg_cmd.data = data;
        i_reg_req = 1'b1;
        n = 0;
        step();
        while (!o_reg_ack && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (!o_reg_ack)
        begin
            give_up("no ack for a register request");
            return;
        end
        rdata = o_reg_rdata;
        if (wr && addr == emul_pkg::ADDR_PERIOD)
            period = int'(data);
        if (wr && addr == emul_pkg::ADDR_ENABLE)
            enabled = (data != '0);
        i_reg_req = 1'b0;
        n = 0;
        step();
        while (o_reg_ack && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (o_reg_ack)
        begin
            give_up("ack did not drop after the request went low");
            return;
        end
        compare_count("o_fifo_reset pulses", resets_seen - resets_before,
                      (wr && addr == emul_pkg::ADDR_FIFO_ERR) ? 1 : 0);
    endtask

    task automatic run_frames(int frames, int exp_strobe, int exp_soa);
        int n;
        int hi_strobe;
        int hi_soa;
        int words_before;
        int limit;
        limit = 2 * (period + 1) + 8;
        hi_strobe = 0;
        hi_soa = 0;
        words_before = words;
        if (!enabled)
        begin
            // disabled, gates and writes must stay quiet
            repeat (frames * (period + 1))
            begin
                step();
                if (o_strobe)
                    hi_strobe++;
                if (o_soa)
                    hi_soa++;
            end
            compare_count("o_strobe high cycles", hi_strobe, exp_strobe);
            compare_count("o_soa high cycles", hi_soa, exp_soa);
            compare_count("o_fifo_wr count", words - words_before, 0);
            return;
        end
        n = 0;
        step();
        while (!strobe_rose && n < limit)
        begin
            step();
            n++;
        end
        if (!strobe_rose)
        begin
            give_up("no rising strobe edge");
            return;
        end
        repeat (frames)
        begin
            n = 0;
            hi_strobe = 0;
            hi_soa = 0;
            words_before = words;
            do
            begin
                if (o_strobe)
                    hi_strobe++;
                if (o_soa)
                    hi_soa++;
                n++;
                step();
            end
            while (!strobe_rose && n < limit);
            if (!strobe_rose)
            begin
                give_up("strobe stopped within a frame run");
                return;
            end
            compare_count("frame length", n, period + 1);
            compare_count("o_strobe high cycles", hi_strobe, exp_strobe);
            compare_count("o_soa high cycles", hi_soa, exp_soa);
            compare_count("words per frame", words - words_before,
                          (period + 1) / emul_pkg::SAMPLES_PER_WORD);
        end
    endtask

    task automatic full_window(int delay, int len);
        int n;
        int drops_before;
        logic [emul_pkg::REG_W-1:0] rd;
        drops_before = drops;
        repeat (delay)
            step();
        full_req = 1'b1;
        repeat (len)
            step();
        full_req = 1'b0;
        if (drops == drops_before)
        begin
            errors++;
            $display("full window covered no slot 3 cycle");
            return;
        end
        n = 0;
        while (gap_pending && n < 4 * (period + 1))
        begin
            step();
            n++;
        end
        if (gap_pending)
        begin
            give_up("writes did not resume after the full window");
            return;
        end
        reg_access(1'b0, emul_pkg::ADDR_FIFO_ERR, '0, rd);
        compare_reg("fifo error count", rd, emul_pkg::REG_W'(drops));
    endtask

    task automatic over_range_pulse(int exp_cycles);
        int n;
        or_req = 1'b1;
        step();
        or_req = 1'b0;
        n = 0;
        while (!o_over_range && n < WAIT_LIMIT)
        begin
            step();
            n++;
        end
        if (!o_over_range)
        begin
            give_up("over-range flag never rose");
            return;
        end
        n = 0;
        while (o_over_range && n < WAIT_LIMIT)
        begin
            n++;
            step();
        end
        compare_count("o_over_range high cycles", n, exp_cycles);
    endtask

    initial
    begin
        int idx;
        int tests;
        int passed;
        int fails_before;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [emul_pkg::REG_W-1:0] rd;
        reset = 1'b0;
        i_reg_req = 1'b0;
        i_reg_cmd = '0;
        i_adc_p = '0;
        i_adc_n = '0;
        i_adc_or = 1'b0;
        i_fifo_full = 1'b0;
        adc_cnt = '0;
        last_first = '0;
        full_req = 1'b0;
        or_req = 1'b0;
        strobe_prev = 1'b0;
        strobe_rose = 1'b0;
        pos_valid = 1'b0;
        have_last = 1'b0;
        gap_pending = 1'b0;
        enabled = 1'b0;
        aborted = 1'b0;
        period = int'(emul_pkg::DEF_PERIOD);
        pos = 0;
        drops = 0;
        resets_seen = 0;
        words = 0;
        errors = 0;
        tests = 0;
        passed = 0;
        for (int i = 0; i < STIM_WORDS; i++)
            stim[i] = '0;
        $readmemh("testbench/adc_emul_stim.txt", stim);
        repeat (10)
            step();
        reset = 1'b1;
        idx = 0;
        // four words per line, op 0 ends the list
        while (idx + 3 < STIM_WORDS && stim[idx] != '0 && !aborted)
        begin
            fails_before = errors;
            op = stim[idx];
            a = stim[idx+1];
            b = stim[idx+2];
            c = stim[idx+3];
            case (op)
                1: reg_access(1'b1, a[emul_pkg::ADDR_W-1:0], b, rd);
                2:
                begin
                    reg_access(1'b0, a[emul_pkg::ADDR_W-1:0], '0, rd);
                    compare_reg("o_reg_rdata", rd, b);
                end
                3: run_frames(int'(a), int'(b), int'(c));
                4: full_window(int'(a), int'(b));
                5: over_range_pulse(int'(b));
                default:
                begin
                    errors++;
                    $display("unknown operation %0d in the stimulus file", op);
                end
            endcase
            tests++;
            if (errors == fails_before)
                passed++;
            $display("test %0d op %0d: %s", tests, op, (errors == fails_before) ? "pass" : "fail");
            idx += 4;
        end
        $display("tests %0d, passed %0d, failed checks %0d", tests, passed, errors);
        if (errors == 0 && tests > 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
